/* design/paint_pkg.sv */
package paint_pkg;

  // ####################
  // Canvas geometry
  // ####################

  localparam int CANVAS_DIM = 64;                   // Width and height in pixels
  localparam int COORD_W    = $clog2(CANVAS_DIM);   // Bits per coordinate
  localparam int PIXEL_W    = 8;                    // Bits per colour

  // ####################
  // Preview bursts
  // ####################

  localparam int CURSOR_LEN = 4;  // Cycles of cursor preview per pass
  localparam int PAL_LEN    = 2;  // Cycles of palette preview per pass

  // ####################
  // Types
  // ####################

  typedef logic [COORD_W-1:0] coord_t;  // Row or column index
  typedef logic [PIXEL_W-1:0] pixel_t;  // Colour value

  // One pixel write into the canvas, also reused for the scan stream
  typedef struct packed {
    coord_t x;
    coord_t y;
    pixel_t color;
  } canvas_wr_t;

endpackage

/* design/control_paint.sv */
`timescale 1ns/10ps

module control_paint
  import paint_pkg::*;
#(
  parameter int CURSOR_LEN = paint_pkg::CURSOR_LEN,
  parameter int PAL_LEN    = paint_pkg::PAL_LEN
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       init,
  input  logic       key_c,
  input  logic       key_enter,
  input  logic       key_enter_pal,
  input  coord_t     ptr_x,
  input  coord_t     ptr_y,
  input  pixel_t     cursor_px,
  input  pixel_t     pal_px,
  input  logic       cursor_done,
  input  logic       pal_done,
  output canvas_wr_t wr,
  output logic       wr_stb,
  output logic       cursor_en,
  output logic       pal_en,
  output pixel_t     preview_px,
  output logic       preview_valid,
  output pixel_t     brush_color
);

  typedef enum logic [3:0] {
    START,
    INIT,
    CHECK_C,
    CHECK_ENTER,
    PAINT,
    DRAW_CURSOR,
    PALETTE_CURSOR,
    CHECK_ENTER_PALETTE,
    CHANGE_COLOR
  } state_t;

  state_t state;
  state_t state_next;

  // ####################
  // State sequencing
  // ####################

  always_comb begin
    state_next = state;
    case (state)
      START:               state_next = init ? INIT : START;
      INIT:                state_next = CHECK_C;
      CHECK_C:             state_next = key_c ? PALETTE_CURSOR : CHECK_ENTER;
      CHECK_ENTER:         state_next = key_enter ? PAINT : DRAW_CURSOR;
      PAINT:               state_next = INIT;
      DRAW_CURSOR:         state_next = cursor_done ? INIT : DRAW_CURSOR;
      PALETTE_CURSOR:      state_next = pal_done ? CHECK_ENTER_PALETTE : PALETTE_CURSOR;
      CHECK_ENTER_PALETTE: state_next = key_enter_pal ? CHANGE_COLOR : PALETTE_CURSOR;
      CHANGE_COLOR:        state_next = INIT;
      default:             state_next = START;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= START;
    end else begin
      state <= state_next;
    end
  end

  // ####################
  // Datapath
  // ####################

  always_ff @(posedge clk) begin
    if (state == INIT) begin
      wr.x <= ptr_x;  // Pointer sampled once per pass
      wr.y <= ptr_y;
    end
    if ((state == CHECK_ENTER) && key_enter) begin
      wr.color <= brush_color;  // Ready before the strobe in PAINT
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      brush_color <= '0;
    end else if (state == CHANGE_COLOR) begin
      brush_color <= {ptr_x[3:0], ptr_y[3:0]};  // Palette column above palette row
    end
  end

  // ####################
  // State decoded outputs
  // ####################

  assign wr_stb        = (state == PAINT);
  assign cursor_en     = (state == DRAW_CURSOR);
  assign pal_en        = (state == PALETTE_CURSOR);
  assign preview_valid = cursor_en || pal_en;

  always_comb begin
    preview_px = '0;
    if (cursor_en) begin
      preview_px = cursor_px;
    end else if (pal_en) begin
      preview_px = pal_px;
    end
  end

endmodule

/* design/cursor_sprite.sv */
`timescale 1ns/10ps

module cursor_sprite
  import paint_pkg::*;
#(
  parameter int LEN = CURSOR_LEN
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   en,
  input  pixel_t brush,
  output pixel_t px,
  output logic   done
);

  localparam int CW = (LEN > 1) ? $clog2(LEN) : 1;

  logic [CW-1:0] cnt;
  logic          last;

  // ####################
  // Burst counter
  // ####################

  assign last = (cnt == CW'(LEN - 1));

  always_ff @(posedge clk) begin
    if (rst || !en) begin
      cnt <= '0;  // Idle between bursts
    end else if (last) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign done = en && last;  // High in the final cycle of the burst

  // ####################
  // Preview pixel
  // ####################

  // Inverted brush keeps the cursor visible over its own colour
  always_ff @(posedge clk) begin
    px <= ~brush;
  end

endmodule

/* design/palette_cursor.sv */
`timescale 1ns/10ps

module palette_cursor
  import paint_pkg::*;
#(
  parameter int LEN = PAL_LEN
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   en,
  input  coord_t ptr_x,
  input  coord_t ptr_y,
  output pixel_t px,
  output logic   done
);

  localparam int CW = (LEN > 1) ? $clog2(LEN) : 1;

  logic [CW-1:0] cnt;
  logic          last;

  // ####################
  // Burst counter
  // ####################

  assign last = (cnt == CW'(LEN - 1));

  always_ff @(posedge clk) begin
    if (rst || !en) begin
      cnt <= '0;
    end else if (last) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign done = en && last;

  // The palette is a 16 by 16 grid, so only the low nibbles select a colour
  always_ff @(posedge clk) begin
    px <= {ptr_x[3:0], ptr_y[3:0]};
  end

endmodule

/* design/canvas_bank.sv */
`timescale 1ns/10ps

module canvas_bank
  import paint_pkg::*;
#(
  parameter int BANK_INDEX = 0,
  parameter int ROWS       = 16
) (
  input  logic                                  clk,
  input  canvas_wr_t                            wr,
  input  logic                                  wr_stb,
  input  logic [((ROWS > 1) ? $clog2(ROWS) : 1)-1:0] rd_row,
  input  coord_t                                rd_col,
  output pixel_t                                rd_px
);

  localparam int RW = (ROWS > 1) ? $clog2(ROWS) : 1;

  pixel_t          mem [ROWS][CANVAS_DIM];
  logic            wr_hit;
  logic   [RW-1:0] wr_row;

  // ####################
  // Write port
  // ####################

  assign wr_hit = ((int'(wr.y) / ROWS) == BANK_INDEX);  // Row lies in this bank
  assign wr_row = RW'(int'(wr.y) % ROWS);

  always_ff @(posedge clk) begin
    if (wr_stb && wr_hit) begin
      mem[wr_row][wr.x] <= wr.color;
    end
  end

  // ####################
  // Read port
  // ####################

  always_ff @(posedge clk) begin
    rd_px <= mem[rd_row][rd_col];  // One cycle read latency
  end

endmodule

/* design/canvas_scanout.sv */
`timescale 1ns/10ps

module canvas_scanout
  import paint_pkg::*;
#(
  parameter int NUM_BANKS = 4
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    scan_start,
  input  pixel_t                                  bank_px [NUM_BANKS],
  output logic [((CANVAS_DIM / NUM_BANKS > 1) ?
                 $clog2(CANVAS_DIM / NUM_BANKS) : 1)-1:0] rd_row,
  output coord_t                                  rd_col,
  output canvas_wr_t                              scan_px,
  output logic                                    scan_valid,
  output logic                                    scan_done
);

  localparam int ROWS_PER_BANK = CANVAS_DIM / NUM_BANKS;
  localparam int RW            = (ROWS_PER_BANK > 1) ? $clog2(ROWS_PER_BANK) : 1;
  localparam int BW            = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  logic            busy;
  coord_t          x_cnt;
  coord_t          y_cnt;
  logic            last_addr;
  coord_t          tag_x;
  coord_t          tag_y;
  logic   [BW-1:0] tag_bank;
  logic            tag_last;
  logic            tag_valid;

  // ####################
  // Raster address counter
  // ####################

  assign last_addr = (x_cnt == coord_t'(CANVAS_DIM - 1)) && (y_cnt == coord_t'(CANVAS_DIM - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= 1'b0;
      x_cnt <= '0;
      y_cnt <= '0;
    end else if (busy) begin
      x_cnt <= x_cnt + 1'b1;  // Wraps to the next row
      if (x_cnt == coord_t'(CANVAS_DIM - 1)) begin
        y_cnt <= y_cnt + 1'b1;
      end
      if (last_addr) begin
        busy <= 1'b0;
      end
    end else if (scan_start) begin
      busy <= 1'b1;  // Start requests while busy fall through here unseen
    end
  end

  assign rd_row = RW'(int'(y_cnt) % ROWS_PER_BANK);
  assign rd_col = x_cnt;

  // ####################
  // Read data pairing
  // ####################

  always_ff @(posedge clk) begin
    tag_x    <= x_cnt;
    tag_y    <= y_cnt;
    tag_bank <= BW'(int'(y_cnt) / ROWS_PER_BANK);
    tag_last <= last_addr;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tag_valid <= 1'b0;
      scan_done <= 1'b0;
    end else begin
      tag_valid <= busy;                   // Matches the bank read register
      scan_done <= tag_valid && tag_last;  // Cycle after the final pixel
    end
  end

  assign scan_valid    = tag_valid;
  assign scan_px.x     = tag_x;
  assign scan_px.y     = tag_y;
  assign scan_px.color = bank_px[tag_bank];

endmodule

/* design/paint_top.sv */
`timescale 1ns/10ps

module paint_top
  import paint_pkg::*;
#(
  parameter int NUM_BANKS  = 4,
  parameter int CURSOR_LEN = paint_pkg::CURSOR_LEN,
  parameter int PAL_LEN    = paint_pkg::PAL_LEN
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       init,
  input  logic       key_c,
  input  logic       key_enter,
  input  logic       key_enter_pal,
  input  coord_t     ptr_x,
  input  coord_t     ptr_y,
  input  logic       scan_start,
  output pixel_t     preview_px,
  output logic       preview_valid,
  output pixel_t     brush_color,
  output canvas_wr_t scan_px,
  output logic       scan_valid,
  output logic       scan_done
);

  localparam int ROWS_PER_BANK = CANVAS_DIM / NUM_BANKS;
  localparam int RW            = (ROWS_PER_BANK > 1) ? $clog2(ROWS_PER_BANK) : 1;

  canvas_wr_t          wr;
  logic                wr_stb;
  logic                cursor_en;
  logic                pal_en;
  logic                cursor_done;
  logic                pal_done;
  pixel_t              cursor_px;
  pixel_t              pal_px;
  logic       [RW-1:0] rd_row;
  coord_t              rd_col;
  pixel_t              bank_px [NUM_BANKS];

  // ####################
  // Paint control
  // ####################

  control_paint #(
    .CURSOR_LEN(CURSOR_LEN),
    .PAL_LEN   (PAL_LEN)
  ) u_control (
    .clk          (clk),
    .rst          (rst),
    .init         (init),
    .key_c        (key_c),
    .key_enter    (key_enter),
    .key_enter_pal(key_enter_pal),
    .ptr_x        (ptr_x),
    .ptr_y        (ptr_y),
    .cursor_px    (cursor_px),
    .pal_px       (pal_px),
    .cursor_done  (cursor_done),
    .pal_done     (pal_done),
    .wr           (wr),
    .wr_stb       (wr_stb),
    .cursor_en    (cursor_en),
    .pal_en       (pal_en),
    .preview_px   (preview_px),
    .preview_valid(preview_valid),
    .brush_color  (brush_color)
  );

  cursor_sprite #(.LEN(CURSOR_LEN)) u_cursor (
    .clk  (clk),
    .rst  (rst),
    .en   (cursor_en),
    .brush(brush_color),
    .px   (cursor_px),
    .done (cursor_done)
  );

  palette_cursor #(.LEN(PAL_LEN)) u_palette (
    .clk  (clk),
    .rst  (rst),
    .en   (pal_en),
    .ptr_x(ptr_x),
    .ptr_y(ptr_y),
    .px   (pal_px),
    .done (pal_done)
  );

  // ####################
  // Canvas and scan-out
  // ####################

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    canvas_bank #(
      .BANK_INDEX(b),
      .ROWS      (ROWS_PER_BANK)
    ) u_bank (
      .clk   (clk),
      .wr    (wr),
      .wr_stb(wr_stb),
      .rd_row(rd_row),
      .rd_col(rd_col),
      .rd_px (bank_px[b])
    );
  end

  canvas_scanout #(.NUM_BANKS(NUM_BANKS)) u_scanout (
    .clk       (clk),
    .rst       (rst),
    .scan_start(scan_start),
    .bank_px   (bank_px),
    .rd_row    (rd_row),
    .rd_col    (rd_col),
    .scan_px   (scan_px),
    .scan_valid(scan_valid),
    .scan_done (scan_done)
  );

endmodule

/* sim/paint_tb.sv */
`timescale 1ns/10ps

module paint_tb
  import paint_pkg::*;
;

  localparam int TOTAL_PX = CANVAS_DIM * CANVAS_DIM;

  logic       clk;
  logic       rst;
  logic       init;
  logic       key_c;
  logic       key_enter;
  logic       key_enter_pal;
  coord_t     ptr_x;
  coord_t     ptr_y;
  logic       scan_start;
  pixel_t     preview_px;
  logic       preview_valid;
  pixel_t     brush_color;
  canvas_wr_t scan_px;
  logic       scan_valid;
  logic       scan_done;

  pixel_t     model [CANVAS_DIM][CANVAS_DIM];  // Reference canvas
  pixel_t     model_brush;
  pixel_t     exp_brush;
  coord_t     pal_x;
  coord_t     pal_y;
  logic       cur_phase;
  logic       pal_phase;
  int         run_len;
  int         scan_idx;
  int         done_cnt;
  int         check_errs;
  int         timeout_errs;

  paint_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .init         (init),
    .key_c        (key_c),
    .key_enter    (key_enter),
    .key_enter_pal(key_enter_pal),
    .ptr_x        (ptr_x),
    .ptr_y        (ptr_y),
    .scan_start   (scan_start),
    .preview_px   (preview_px),
    .preview_valid(preview_valid),
    .brush_color  (brush_color),
    .scan_px      (scan_px),
    .scan_valid   (scan_valid),
    .scan_done    (scan_done)
  );

  always #2 clk = ~clk;

  // ####################
  // Stream bookkeeping
  // ####################

  always_ff @(posedge clk) begin
    if (rst) begin
      run_len  <= 0;
      scan_idx <= 0;
      done_cnt <= 0;
    end else begin
      run_len <= preview_valid ? run_len + 1 : 0;  // Length of the current preview burst
      if (scan_valid) begin
        scan_idx <= scan_idx + 1;
      end
      if (scan_done) begin
        done_cnt <= done_cnt + 1;
      end
    end
  end

  // ####################
  // Checks
  // ####################

  a_reset_flags: assert property (@(posedge clk)
    $fell(rst) |-> (!preview_valid && !scan_valid && !scan_done))
    else begin
      check_errs++;
      $display("CHECK FAILED t=%0t preview_valid/scan_valid/scan_done got=%b%b%b exp=000",
               $time, preview_valid, scan_valid, scan_done);
    end

  a_reset_brush: assert property (@(posedge clk) $fell(rst) |-> brush_color == 8'h00)
    else begin
      check_errs++;
      $display("CHECK FAILED t=%0t brush_color got=%h exp=00", $time, brush_color);
    end

  a_brush_change: assert property (@(posedge clk) disable iff (rst)
    $changed(brush_color) |-> brush_color == exp_brush)
    else begin
      check_errs++;
      $display("CHECK FAILED t=%0t brush_color got=%h exp=%h", $time, brush_color, exp_brush);
    end

  a_cursor_px: assert property (@(posedge clk) disable iff (rst)
    (cur_phase && preview_valid) |-> preview_px == ~model_brush)
    else begin
      check_errs++;
      $display("CHECK FAILED t=%0t preview_px got=%h exp=%h", $time, preview_px, ~model_brush);
    end

  a_cursor_len: assert property (@(posedge clk) disable iff (rst)
    (cur_phase && $fell(preview_valid)) |-> run_len == CURSOR_LEN)
    else begin
      check_errs++;
      $display("CHECK FAILED t=%0t preview_valid length got=%0d exp=%0d",
               $time, run_len, CURSOR_LEN);
    end

  a_pal_px: assert property (@(posedge clk) disable iff (rst)
    (pal_phase && preview_valid) |-> preview_px == {pal_x[3:0], pal_y[3:0]})
    else begin
      check_errs++;
      $display("CHECK FAILED t=%0t preview_px got=%h exp=%h",
               $time, preview_px, {pal_x[3:0], pal_y[3:0]});
    end

  a_scan_x: assert property (@(posedge clk) disable iff (rst)
    scan_valid |-> int'(scan_px.x) == scan_idx % CANVAS_DIM)
    else begin
      check_errs++;
      $display("CHECK FAILED t=%0t scan_px.x got=%0d exp=%0d",
               $time, scan_px.x, scan_idx % CANVAS_DIM);
    end

  a_scan_y: assert property (@(posedge clk) disable iff (rst)
    scan_valid |-> int'(scan_px.y) == scan_idx / CANVAS_DIM)
    else begin
      check_errs++;
      $display("CHECK FAILED t=%0t scan_px.y got=%0d exp=%0d",
               $time, scan_px.y, scan_idx / CANVAS_DIM);
    end

  a_scan_color: assert property (@(posedge clk) disable iff (rst)
    scan_valid |-> scan_px.color == model[scan_idx / CANVAS_DIM][scan_idx % CANVAS_DIM])
    else begin
      check_errs++;
      $display("CHECK FAILED t=%0t scan_px.color got=%h exp=%h",
               $time, scan_px.color, model[scan_idx / CANVAS_DIM][scan_idx % CANVAS_DIM]);
    end

  // A gap or an early end shows up as valid falling before the full count
  a_scan_gap: assert property (@(posedge clk) disable iff (rst)
    $fell(scan_valid) |-> scan_idx == TOTAL_PX)
    else begin
      check_errs++;
      $display("CHECK FAILED t=%0t scan pixel count got=%0d exp=%0d", $time, scan_idx, TOTAL_PX);
    end

  a_scan_done: assert property (@(posedge clk) disable iff (rst)
    scan_done |-> (scan_idx == TOTAL_PX && !scan_valid && done_cnt == 0))
    else begin
      check_errs++;
      $display("Scan done pulse came at the wrong time or more than once, t=%0t", $time);
    end

  // ####################
  // Stimulus tasks
  // ####################

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic finish_run();
    $display("Errors: check=%0d timeout=%0d", check_errs, timeout_errs);
    if (check_errs == 0 && timeout_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  // Keys at rest run cursor passes; the cursor bursts are checked in a settled window
  task automatic settle_idle();
    key_c     <= 1'b0;
    key_enter <= 1'b0;
    key_enter_pal <= 1'b1;
    wait_cycles(16);
    cur_phase <= 1'b1;
    wait_cycles(24);
    cur_phase <= 1'b0;
  endtask

  task automatic palette_select(input coord_t x, input coord_t y);
    int n;
    n = 0;
    ptr_x <= x;
    ptr_y <= y;
    pal_x <= x;
    pal_y <= y;
    exp_brush <= {x[3:0], y[3:0]};
    wait_cycles(12);
    key_c         <= 1'b1;
    key_enter_pal <= 1'b0;  // Stay in the palette loop for a while
    wait_cycles(12);
    pal_phase <= 1'b1;
    wait_cycles(24);
    pal_phase     <= 1'b0;
    key_enter_pal <= 1'b1;
    while (brush_color != {x[3:0], y[3:0]} && n <= 50) begin
      n++;
      @(posedge clk);
    end
    if (brush_color != {x[3:0], y[3:0]}) begin
      timeout_errs++;
      $display("Timeout: brush colour never took the palette selection");
      finish_run();
    end else begin
      model_brush = {x[3:0], y[3:0]};
      wait_cycles(8);
      settle_idle();
    end
  endtask

  // Pointer settles under idle keys so the first write lands on it
  task automatic begin_paint(input coord_t x, input coord_t y);
    ptr_x <= x;
    ptr_y <= y;
    wait_cycles(12);
    key_enter <= 1'b1;
    model[y][x] = model_brush;
    wait_cycles(12);
  endtask

  // One paint pass is four cycles, so each held pointer is sampled once
  task automatic paint_at(input coord_t x, input coord_t y);
    ptr_x <= x;
    ptr_y <= y;
    model[y][x] = model_brush;
    wait_cycles(4);
  endtask

  task automatic run_scan();
    int n;
    n = 0;
    scan_start <= 1'b1;
    @(posedge clk);
    scan_start <= 1'b0;
    wait_cycles(20);
    scan_start <= 1'b1;  // Must be ignored by the running scan
    @(posedge clk);
    scan_start <= 1'b0;
    while (!scan_done && n <= 3 * TOTAL_PX) begin
      n++;
      @(posedge clk);
    end
    if (!scan_done) begin
      timeout_errs++;
      $display("Timeout: scan never signalled done");
      finish_run();
    end else begin
      wait_cycles(8);
      a_scan_total: assert (done_cnt == 1 && scan_idx == TOTAL_PX)
        else begin
          check_errs++;
          $display("CHECK FAILED t=%0t scan_done count got=%0d exp=1, pixels got=%0d exp=%0d",
                   $time, done_cnt, scan_idx, TOTAL_PX);
        end
    end
  endtask

  // ####################
  // Main sequence
  // ####################

  initial begin
    void'($urandom(11899));
    clk = 1'b0;
    rst = 1'b1;
    init = 1'b0;
    key_c = 1'b0;
    key_enter = 1'b0;
    key_enter_pal = 1'b1;
    ptr_x = '0;
    ptr_y = '0;
    scan_start = 1'b0;
    model_brush = '0;
    exp_brush = '0;
    pal_x = '0;
    pal_y = '0;
    cur_phase = 1'b0;
    pal_phase = 1'b0;
    check_errs = 0;
    timeout_errs = 0;

    wait_cycles(16);
    rst  <= 1'b0;
    init <= 1'b1;
    settle_idle();

    // Known start colour over the whole canvas
    palette_select(6'd5, 6'd10);
    begin_paint(6'd0, 6'd0);
    for (int i = 1; i < TOTAL_PX; i++) begin
      paint_at(coord_t'(i % CANVAS_DIM), coord_t'(i / CANVAS_DIM));
    end
    settle_idle();

    for (int r = 0; r < 3; r++) begin
      palette_select(coord_t'($urandom % CANVAS_DIM), coord_t'($urandom % CANVAS_DIM));
      begin_paint(coord_t'($urandom % CANVAS_DIM), coord_t'($urandom % CANVAS_DIM));
      for (int i = 0; i < 200; i++) begin
        paint_at(coord_t'($urandom % CANVAS_DIM), coord_t'($urandom % CANVAS_DIM));
      end
      settle_idle();
    end

    run_scan();
    finish_run();
  end

endmodule

/* compile.f */
design/paint_pkg.sv
design/control_paint.sv
design/cursor_sprite.sv
design/palette_cursor.sv
design/canvas_bank.sv
design/canvas_scanout.sv
design/paint_top.sv
sim/paint_tb.sv
